//--- ring_bus.sv
// ring bus top level
// builds NUM_UNITS nodes, each a transmit FIFO, a ring unit and a
// receive FIFO, and closes the ring from the last unit to the first
// outside ports are loose arrays indexed by unit number

`default_nettype none

module ring_bus #(
	parameter int NUM_UNITS = ring_cfg_pkg::DEFAULT_NUM_UNITS,
	parameter int FIFO_DEPTH = ring_cfg_pkg::DEFAULT_FIFO_DEPTH
) (
	input wire clk,
	input wire reset,

	// transmit queues
	input wire tx_valid [NUM_UNITS],
	output wire tx_ready [NUM_UNITS],
	input wire ring_msg_pkg::unit_id_t tx_id_to [NUM_UNITS],
	input wire ring_msg_pkg::ring_data_t tx_data [NUM_UNITS],

	// receive queues
	output wire rx_valid [NUM_UNITS],
	input wire rx_ready [NUM_UNITS],
	output wire ring_msg_pkg::unit_id_t rx_id_from [NUM_UNITS],
	output wire ring_msg_pkg::ring_data_t rx_data [NUM_UNITS]
);

	import ring_cfg_pkg::*;
	import ring_msg_pkg::*;

	if (NUM_UNITS < 1 || NUM_UNITS > MAX_UNITS) begin : g_bad_size
		$error("ring_bus supports 1 to %0d units", MAX_UNITS);
	end

	// ------------------------------
	// ring links, entry k is unit k's sink
	// ------------------------------

	wire unit_id_t link_id_to [NUM_UNITS];
	wire unit_id_t link_id_from [NUM_UNITS];
	wire ring_data_t link_data [NUM_UNITS];
	wire link_valid [NUM_UNITS];

	for (genvar k = 0; k < NUM_UNITS; k++) begin : g_node
		// upstream neighbour, unit 0 takes from the last unit
		localparam int PREV = (k == 0) ? NUM_UNITS - 1 : k - 1;

		wire tx_msg_t tx_in;
		wire tx_msg_t tx_out;
		wire tx_out_valid;
		wire tx_pop;

		wire unit_id_t m_id_from;
		wire ring_data_t m_data;
		wire m_valid;
		wire m_ready;

		wire rx_msg_t rx_in;
		wire rx_msg_t rx_out;

		assign tx_in = '{id_to: tx_id_to[k], data: tx_data[k]};

		ring_fifo #(
			.DEPTH(FIFO_DEPTH),
			.payload_t(tx_msg_t)
		) tx_fifo_i (
			.clk(clk),
			.reset(reset),
			.in_valid(tx_valid[k]),
			.in_ready(tx_ready[k]),
			.in_data(tx_in),
			.out_valid(tx_out_valid),
			.out_ready(tx_pop),
			.out_data(tx_out)
		);

		ring_bus_unit #(
			.UNIT_ID(unit_id_t'(k))
		) unit_i (
			.clk(clk),
			.reset(reset),
			.s_id_to(tx_out.id_to),
			.s_data(tx_out.data),
			.s_valid(tx_out_valid),
			.s_ready(tx_pop),
			.m_id_from(m_id_from),
			.m_data(m_data),
			.m_valid(m_valid),
			.m_ready(m_ready),
			.src_id_to(link_id_to[PREV]),
			.src_id_from(link_id_from[PREV]),
			.src_data(link_data[PREV]),
			.src_valid(link_valid[PREV]),
			.sink_id_to(link_id_to[k]),
			.sink_id_from(link_id_from[k]),
			.sink_data(link_data[k]),
			.sink_valid(link_valid[k])
		);

		assign rx_in = '{id_from: m_id_from, data: m_data};

		// not-full of the receive queue is the unit's m_ready
		ring_fifo #(
			.DEPTH(FIFO_DEPTH),
			.payload_t(rx_msg_t)
		) rx_fifo_i (
			.clk(clk),
			.reset(reset),
			.in_valid(m_valid),
			.in_ready(m_ready),
			.in_data(rx_in),
			.out_valid(rx_valid[k]),
			.out_ready(rx_ready[k]),
			.out_data(rx_out)
		);

		assign rx_id_from[k] = rx_out.id_from;
		assign rx_data[k] = rx_out.data;

		// no time-to-live, a bad id would circle forever
		a_tx_id_legal: assert property (@(posedge clk) disable iff (reset)
			tx_valid[k] |-> (int'(tx_id_to[k]) < NUM_UNITS))
			else $error("unit %0d sent to nonexistent id %0d", k, tx_id_to[k]);
	end

endmodule

`default_nettype wire

//--- ring_bus_tb.sv
// table-driven testbench for the ring bus top level
// rows of source, destination, data and receiver hold are applied in
// phases; a scoreboard keyed by destination matches every rx transfer

`default_nettype none

module ring_bus_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import ring_cfg_pkg::*;
	import ring_msg_pkg::*;

	localparam int NUM_UNITS = DEFAULT_NUM_UNITS;
	localparam int FIFO_DEPTH = DEFAULT_FIFO_DEPTH;
	localparam int DIRECTED_ROWS = 1 + NUM_UNITS * NUM_UNITS;
	localparam int RX_HOLD_ROWS = FIFO_DEPTH + 3;
	// two more than the rx FIFO, every slot and the tx FIFO can take
	localparam int TX_HOLD_ROWS = NUM_UNITS + 2 * FIFO_DEPTH + 2;
	localparam int RANDOM_ROWS = 40;
	localparam int NUM_ROWS = DIRECTED_ROWS + RX_HOLD_ROWS + TX_HOLD_ROWS + RANDOM_ROWS;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * (NUM_UNITS * FIFO_DEPTH + 10) + 200;
	// ample time for every queue and slot to empty once holds are over
	localparam int DRAIN_CYCLES = NUM_UNITS * NUM_UNITS * (2 * FIFO_DEPTH + 1);
	localparam int TX_HOLD_SRC = 1;
	localparam int TX_HOLD_DST = 3;

	// exp_lat below zero means latency is not checked
	typedef struct {
		int src;
		int dst;
		ring_data_t data;
		int hold;
		int exp_lat;
	} row_t;

	typedef struct {
		int src;
		ring_data_t data;
		int cycle;
		int lat;
	} pend_t;

	logic clk;
	logic reset;
	logic tx_valid [NUM_UNITS];
	wire tx_ready [NUM_UNITS];
	unit_id_t tx_id_to [NUM_UNITS];
	ring_data_t tx_data [NUM_UNITS];
	wire rx_valid [NUM_UNITS];
	logic rx_ready [NUM_UNITS];
	wire unit_id_t rx_id_from [NUM_UNITS];
	wire ring_data_t rx_data [NUM_UNITS];

	row_t stim [NUM_ROWS];
	pend_t pending [NUM_UNITS][$];
	int hold_left [NUM_UNITS];
	int lat_of [NUM_UNITS];
	logic stall_seen [NUM_UNITS];
	int cycle = 0;
	integer seed = 32'h4b05_50c0;

	tb_clock_gen clock_gen_i (
		.clk(clk),
		.reset(reset)
	);

	ring_bus ring_bus_i (
		.clk(clk),
		.reset(reset),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx_id_to(tx_id_to),
		.tx_data(tx_data),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.rx_id_from(rx_id_from),
		.rx_data(rx_data)
	);

	// ------------------------------
	// reporting
	// ------------------------------

	task automatic stop_with_failure(string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check(string name, int expected, int actual);
		if (expected != actual) begin
			stop_with_failure($sformatf("[FAIL] %s expected %0d actual %0d",
				name, expected, actual));
		end
	endtask

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle > TIMEOUT_CYCLES) begin
			stop_with_failure($sformatf("timeout after %0d cycles, traffic never drained",
				cycle));
		end
	end

	// ------------------------------
	// scoreboard
	// ------------------------------

	// hops to the destination, a self-addressed message does a full lap
	function automatic int hop_latency(int src, int dst);
		int d;
		d = (dst - src + NUM_UNITS) % NUM_UNITS;
		if (d == 0) begin
			d = NUM_UNITS;
		end
		return d + 2;
	endfunction

	function automatic int pending_total();
		int n;
		n = 0;
		for (int u = 0; u < NUM_UNITS; u++) begin
			n += pending[u].size();
		end
		return n;
	endfunction

	task automatic match_rx(int u);
		int hit;
		hit = -1;
		for (int i = 0; i < pending[u].size(); i++) begin
			if (hit < 0 && pending[u][i].src == int'(rx_id_from[u])
					&& pending[u][i].data == rx_data[u]) begin
				hit = i;
			end
		end
		if (hit < 0) begin
			stop_with_failure($sformatf("unit %0d got data %h from unit %0d that was never sent",
				u, rx_data[u], rx_id_from[u]));
		end else begin
			if (pending[u][hit].lat >= 0) begin
				check($sformatf("latency %0d to %0d", pending[u][hit].src, u),
					pending[u][hit].lat, cycle - pending[u][hit].cycle);
			end
			pending[u].delete(hit);
		end
	endtask

	// sampled at the falling edge, transfers happen on the next rising edge
	always @(negedge clk) begin
		pend_t entry;
		if (!reset) begin
			for (int u = 0; u < NUM_UNITS; u++) begin
				if (tx_valid[u] && tx_ready[u]) begin
					entry.src = u;
					entry.data = tx_data[u];
					entry.cycle = cycle;
					entry.lat = lat_of[u];
					pending[int'(tx_id_to[u])].push_back(entry);
				end
				if (rx_valid[u] && rx_ready[u]) begin
					match_rx(u);
				end
			end
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------

	task automatic build_table();
		int n;
		int rnd;
		stim[0] = '{0, 2, ring_data_t'(16'h5a3c), 0, hop_latency(0, 2)};
		n = 1;
		for (int s = 0; s < NUM_UNITS; s++) begin
			for (int d = 0; d < NUM_UNITS; d++) begin
				stim[n] = '{s, d, ring_data_t'(16'h1000 + n), 0, hop_latency(s, d)};
				n++;
			end
		end
		// all sources but unit 2 flood unit 2
		for (int i = 0; i < RX_HOLD_ROWS; i++) begin
			stim[n] = '{(3 + i % (NUM_UNITS - 1)) % NUM_UNITS, 2,
				ring_data_t'(16'h2000 + i), 30, -1};
			n++;
		end
		for (int i = 0; i < TX_HOLD_ROWS; i++) begin
			stim[n] = '{TX_HOLD_SRC, TX_HOLD_DST, ring_data_t'(16'h3000 + i), 60, -1};
			n++;
		end
		for (int i = 0; i < RANDOM_ROWS; i++) begin
			rnd = $random(seed);
			stim[n].src = (rnd & 'hff) % NUM_UNITS;
			stim[n].dst = ((rnd >> 8) & 'hff) % NUM_UNITS;
			stim[n].hold = (((rnd >> 16) & 7) == 0) ? 1 + ((rnd >> 20) & 15) : 0;
			stim[n].data = ring_data_t'($random(seed));
			stim[n].exp_lat = -1;
			n++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
		for (int u = 0; u < NUM_UNITS; u++) begin
			if (hold_left[u] > 0) begin
				hold_left[u]--;
			end
			rx_ready[u] = (hold_left[u] == 0);
		end
	endtask

	// let every receiver hold run out, then give the ring a bounded time to drain
	task automatic wait_idle();
		int held;
		int waited;
		held = 1;
		while (held != 0) begin
			held = 0;
			for (int u = 0; u < NUM_UNITS; u++) begin
				held += hold_left[u];
			end
			if (held != 0) begin
				next_cycle();
			end
		end
		waited = 0;
		while (pending_total() != 0 && waited < DRAIN_CYCLES) begin
			next_cycle();
			waited++;
		end
	endtask

	task automatic send_row(int r);
		int src;
		int dst;
		logic accepted;
		src = stim[r].src;
		dst = stim[r].dst;
		if (stim[r].hold > hold_left[dst]) begin
			hold_left[dst] = stim[r].hold;
		end
		rx_ready[dst] = (hold_left[dst] == 0);
		lat_of[src] = stim[r].exp_lat;
		tx_valid[src] = 1'b1;
		tx_id_to[src] = unit_id_t'(dst);
		tx_data[src] = stim[r].data;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = tx_ready[src];
			if (!accepted) begin
				stall_seen[src] = 1'b1;
			end
			next_cycle();
		end
		tx_valid[src] = 1'b0;
	endtask

	// rows with a latency go out alone on an idle ring
	task automatic run_rows(int first, int count);
		for (int r = first; r < first + count; r++) begin
			if (stim[r].exp_lat >= 0) begin
				wait_idle();
				send_row(r);
				wait_idle();
			end else begin
				send_row(r);
			end
		end
	endtask

	initial begin
		for (int u = 0; u < NUM_UNITS; u++) begin
			tx_valid[u] = 1'b0;
			tx_id_to[u] = '0;
			tx_data[u] = '0;
			rx_ready[u] = 1'b1;
			hold_left[u] = 0;
			lat_of[u] = -1;
			stall_seen[u] = 1'b0;
		end
		build_table();
		wait (reset == 1'b0);
		@(negedge clk);
		for (int u = 0; u < NUM_UNITS; u++) begin
			check($sformatf("rx_valid[%0d] after reset", u), 0, int'(rx_valid[u]));
			check($sformatf("tx_ready[%0d] after reset", u), 1, int'(tx_ready[u]));
		end
		next_cycle();

		run_rows(0, DIRECTED_ROWS);
		check("pending after directed pairs", 0, pending_total());

		run_rows(DIRECTED_ROWS, RX_HOLD_ROWS);
		wait_idle();
		check("pending after rx back-pressure", 0, pending_total());

		stall_seen[TX_HOLD_SRC] = 1'b0;
		run_rows(DIRECTED_ROWS + RX_HOLD_ROWS, TX_HOLD_ROWS);
		wait_idle();
		check("tx_ready drop under tx back-pressure", 1, int'(stall_seen[TX_HOLD_SRC]));
		check("pending after tx back-pressure", 0, pending_total());

		run_rows(NUM_ROWS - RANDOM_ROWS, RANDOM_ROWS);
		wait_idle();
		check("pending after random traffic", 0, pending_total());

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- ring_bus_unit.sv
// one stop on the unidirectional ring
// holds a single slot register, hands matching traffic to the local
// receiver and lets the local transmitter fill an empty or freed slot
// chain sink of one unit into src of the next to build the ring

`default_nettype none

module ring_bus_unit #(
	parameter ring_msg_pkg::unit_id_t UNIT_ID = '0
) (
	input wire clk,
	input wire reset,

	// local transmit side
	input wire ring_msg_pkg::unit_id_t s_id_to,
	input wire ring_msg_pkg::ring_data_t s_data,
	input wire s_valid,
	output logic s_ready,

	// local receive side
	output ring_msg_pkg::unit_id_t m_id_from,
	output ring_msg_pkg::ring_data_t m_data,
	output logic m_valid,
	input wire m_ready,

	// from upstream unit
	input wire ring_msg_pkg::unit_id_t src_id_to,
	input wire ring_msg_pkg::unit_id_t src_id_from,
	input wire ring_msg_pkg::ring_data_t src_data,
	input wire src_valid,

	// to downstream unit
	output ring_msg_pkg::unit_id_t sink_id_to,
	output ring_msg_pkg::unit_id_t sink_id_from,
	output ring_msg_pkg::ring_data_t sink_data,
	output logic sink_valid
);

	import ring_msg_pkg::*;

	// slot payload, meaningful only with slot_valid
	unit_id_t slot_id_to;
	unit_id_t slot_id_from;
	ring_data_t slot_data;
	logic slot_valid;

	logic extract;
	logic insert;

	// ------------------------------
	// address match and handshakes
	// ------------------------------

	assign m_valid = src_valid && (src_id_to == UNIT_ID);
	assign m_id_from = src_id_from;
	assign m_data = src_data;
	assign extract = m_valid && m_ready;

	// slot is free if empty or consumed here this cycle
	assign s_ready = !src_valid || extract;
	assign insert = s_valid && s_ready;

	// ------------------------------
	// slot register
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_valid <= 1'b0;
		end else if (insert) begin
			slot_valid <= 1'b1;
		end else if (extract) begin
			slot_valid <= 1'b0;
		end else begin
			slot_valid <= src_valid;
		end
	end

	// payload follows upstream unless a local message takes the slot
	always_ff @(posedge clk) begin
		if (insert) begin
			slot_id_to <= s_id_to;
			slot_id_from <= UNIT_ID;
			slot_data <= s_data;
		end else begin
			slot_id_to <= src_id_to;
			slot_id_from <= src_id_from;
			slot_data <= src_data;
		end
	end

	assign sink_id_to = slot_id_to;
	assign sink_id_from = slot_id_from;
	assign sink_data = slot_data;
	assign sink_valid = slot_valid;

	// ------------------------------
	// checks
	// ------------------------------

	// traffic not taken here must reach the next slot untouched by an insert
	a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
		(src_valid && !extract) |=> (sink_valid && sink_id_to == $past(src_id_to)
			&& sink_id_from == $past(src_id_from) && sink_data == $past(src_data)))
		else $error("unit %0d inserted over a live message", UNIT_ID);

	a_sink_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(sink_valid))
		else $error("unit %0d sink_valid unknown", UNIT_ID);

endmodule

`default_nettype wire

//--- ring_cfg_pkg.sv
// ring geometry and sizing constants
// shared by the ring rtl and the testbench, referenced by scoped name
// or pulled in with a wildcard import inside a module body

`default_nettype none

package ring_cfg_pkg;

	// ------------------------------
	// ring geometry
	// ------------------------------

	// largest ring the id field can address
	localparam int MAX_UNITS = 16;

	// bits of a unit id, enough for MAX_UNITS stops
	localparam int UNIT_ID_WIDTH = 4;

	// ------------------------------
	// payload and queue sizing
	// ------------------------------

	// data bits carried by one message
	localparam int DATA_WIDTH = 16;

	// top-level defaults
	localparam int DEFAULT_NUM_UNITS = 4;
	localparam int DEFAULT_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

//--- ring_fifo.sv
// show-ahead synchronous FIFO with a type-parameter payload
// out_data is valid whenever out_valid is high; a word pushed into
// an empty FIFO shows up on the following cycle
// used for both the transmit and receive queue of each ring node

`default_nettype none

module ring_fifo #(
	parameter int DEPTH = 4,
	parameter type payload_t = logic
) (
	input wire clk,
	input wire reset,

	input wire in_valid,
	output logic in_ready,
	input wire payload_t in_data,

	output logic out_valid,
	input wire out_ready,
	output payload_t out_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	if (DEPTH < 1) begin : g_bad_depth
		$error("ring_fifo needs a DEPTH of at least 1");
	end

	// storage, no reset needed
	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// wrap at DEPTH so non power of two sizes work
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// ------------------------------
	// handshake
	// ------------------------------

	assign in_ready = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	// head of queue straight from the array
	assign out_data = mem[rd_ptr];

	// ------------------------------
	// storage and pointers
	// ------------------------------

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// simultaneous push and pop keeps the count
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// ------------------------------
	// checks
	// ------------------------------

	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= CNT_W'(DEPTH))
		else $error("fifo occupancy above DEPTH");

	// an empty queue has its pointers together
	a_empty_ptrs: assert property (@(posedge clk) disable iff (reset)
		!out_valid |-> (wr_ptr == rd_ptr))
		else $error("fifo pointers apart while empty");

endmodule

`default_nettype wire

//--- ring_msg_pkg.sv
// message field types and queue payloads for the ring bus
// the transmit queue carries destination and data, the receive
// queue carries source and data

`default_nettype none

package ring_msg_pkg;

	// ------------------------------
	// message fields
	// ------------------------------

	typedef logic [ring_cfg_pkg::UNIT_ID_WIDTH-1:0] unit_id_t;

	typedef logic [ring_cfg_pkg::DATA_WIDTH-1:0] ring_data_t;

	// ------------------------------
	// queue payloads
	// ------------------------------

	// transmit side, source id is added by the unit on insert
	typedef struct packed {
		unit_id_t id_to;
		ring_data_t data;
	} tx_msg_t;

	// receive side, destination is implied by the node
	typedef struct packed {
		unit_id_t id_from;
		ring_data_t data;
	} rx_msg_t;

endpackage

`default_nettype wire

//--- tb_clock_gen.sv
// testbench clock and reset source for the ring bus
// clk runs with a 100 ns period, reset is held high for the first
// RESET_CYCLES rising edges and released just after the last one

`default_nettype none

module tb_clock_gen #(
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// synchronous release, 1 ns after the edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- vlog.f
ring_cfg_pkg.sv
ring_msg_pkg.sv
ring_fifo.sv
ring_bus_unit.sv
ring_bus.sv
tb_clock_gen.sv
ring_bus_tb.sv
